//--- source/rename_pkg.sv
package rename_pkg;

    // register file sizes
    localparam int NUM_REGS   = 64;
    localparam int PHYS_W     = $clog2(NUM_REGS);
    localparam int ARCH_W     = 5;
    localparam int NUM_ARCH   = 2 ** ARCH_W;
    localparam int FREE_DEPTH = NUM_REGS - NUM_ARCH;

    // free list pointers carry one wrap bit above the index
    localparam int FL_IDX_W = $clog2(FREE_DEPTH);
    localparam int FL_PTR_W = FL_IDX_W + 1;

    // writeback ports that can wake a register
    localparam int NUM_WAKE = 3;

    // RV32I major opcodes
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;

    typedef logic [PHYS_W-1:0] phys_t;
    typedef logic [ARCH_W-1:0] arch_t;

    typedef struct packed {
        logic [6:0] funct7;
        arch_t      rs2;
        arch_t      rs1;
        logic [2:0] funct3;
        arch_t      rd;
        logic [6:0] opcode;
    } r_fmt_t;

    // same layout, but bits 11:7 are immediate in stores and branches
    typedef struct packed {
        logic [6:0] imm_hi;
        arch_t      rs2;
        arch_t      rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        s_fmt_t s_fmt;
    } instr_u;

    typedef struct packed {
        logic   valid;
        instr_u instr;
    } rename_req_t;

    typedef struct packed {
        logic  valid;
        phys_t prs1;
        phys_t prs2;
        phys_t prd;
        logic  rs1_ready;
        logic  rs2_ready;
        logic  has_rd;
        phys_t old_prd;
    } renamed_t;

    typedef struct packed {
        logic  valid;
        arch_t arch;
        phys_t phys;
    } wakeup_t;

    typedef struct packed {
        logic  valid;
        logic  has_rd;
        arch_t arch;
        phys_t phys;
    } commit_t;

endpackage

//--- source/rename_decode.sv
module rename_decode (
    input  rename_pkg::instr_u instr,
    output rename_pkg::arch_t  arch_rs1,
    output rename_pkg::arch_t  arch_rs2,
    output rename_pkg::arch_t  arch_rd,
    output logic               writes_rd
);
    import rename_pkg::*;

    logic [6:0] opcode;
    logic       use_rs1;
    logic       use_rs2;
    logic       is_sb;

    assign opcode = instr.r_fmt.opcode;

    // opcode class decides which fields are real registers
    always_comb
    begin
        writes_rd = 1'b0;
        use_rs1   = 1'b0;
        use_rs2   = 1'b0;
        is_sb     = 1'b0;
        case (opcode)
            OP_REG:
            begin
                writes_rd = 1'b1;
                use_rs1   = 1'b1;
                use_rs2   = 1'b1;
            end
            OP_IMM, OP_LOAD, OP_JALR:
            begin
                writes_rd = 1'b1;
                use_rs1   = 1'b1;
            end
            OP_LUI, OP_AUIPC, OP_JAL:
            begin
                writes_rd = 1'b1;
            end
            OP_STORE, OP_BRANCH:
            begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                is_sb   = 1'b1;
            end
            default:
            begin
                writes_rd = 1'b0;
            end
        endcase
    end

    // S and B words go through the s view, rd slot there holds imm_lo
    always_comb
    begin
        if (is_sb)
        begin
            arch_rs1 = instr.s_fmt.rs1;
            arch_rs2 = instr.s_fmt.rs2;
            arch_rd  = '0;
        end
        else
        begin
            arch_rs1 = use_rs1 ? instr.r_fmt.rs1 : '0;
            arch_rs2 = use_rs2 ? instr.r_fmt.rs2 : '0;
            arch_rd  = writes_rd ? instr.r_fmt.rd : '0;
        end
    end

endmodule

//--- source/rat.sv
module rat (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,
    input  rename_pkg::phys_t   committed_map [rename_pkg::NUM_ARCH],
    input  rename_pkg::arch_t   arch_rs1,
    input  rename_pkg::arch_t   arch_rs2,
    input  rename_pkg::arch_t   arch_rd,
    input  logic                alloc,
    input  rename_pkg::phys_t   alloc_phys,
    input  rename_pkg::wakeup_t wake_alu,
    input  rename_pkg::wakeup_t wake_mul,
    input  rename_pkg::wakeup_t wake_ldst,
    output rename_pkg::phys_t   prs1,
    output rename_pkg::phys_t   prs2,
    output rename_pkg::phys_t   old_prd,
    output logic                rs1_ready,
    output logic                rs2_ready
);
    import rename_pkg::*;

    // speculative arch to phys map
    phys_t               map [NUM_ARCH];
    // one ready bit per physical register
    logic [NUM_REGS-1:0] ready;
    wakeup_t             wakes [NUM_WAKE];

    assign wakes[0] = wake_alu;
    assign wakes[1] = wake_mul;
    assign wakes[2] = wake_ldst;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            // x_i maps to p_i out of reset
            for (int i = 0; i < NUM_ARCH; i++)
            begin
                map[i] <= phys_t'(i);
            end
            ready <= '1;
        end
        else if (flush)
        begin
            for (int i = 0; i < NUM_ARCH; i++)
            begin
                map[i] <= committed_map[i];
            end
            ready <= '1;
        end
        else
        begin
            for (int w = 0; w < NUM_WAKE; w++)
            begin
                if (wakes[w].valid && (wakes[w].arch != '0))
                begin
                    ready[wakes[w].phys] <= 1'b1;
                end
            end
            // placed after the wakeups so a same-cycle allocation wins
            if (alloc && (arch_rd != '0))
            begin
                map[arch_rd]      <= alloc_phys;
                ready[alloc_phys] <= 1'b0;
            end
        end
    end

    // lookups see the map before this cycle's update
    always_comb
    begin
        prs1      = (arch_rs1 == '0) ? '0 : map[arch_rs1];
        prs2      = (arch_rs2 == '0) ? '0 : map[arch_rs2];
        old_prd   = (arch_rd == '0) ? '0 : map[arch_rd];
        rs1_ready = (arch_rs1 == '0) ? 1'b1 : ready[prs1];
        rs2_ready = (arch_rs2 == '0) ? 1'b1 : ready[prs2];
    end

endmodule

//--- source/free_list.sv
module free_list (
    input  logic              clk,
    input  logic              rst,
    input  logic              flush,
    input  logic              pop,
    input  logic              commit_alloc,
    input  logic              push,
    input  rename_pkg::phys_t push_phys,
    output rename_pkg::phys_t free_phys,
    output logic              empty
);
    import rename_pkg::*;

    phys_t               entries [FREE_DEPTH];
    logic [FL_PTR_W-1:0] wr_ptr;
    logic [FL_PTR_W-1:0] spec_rd_ptr;
    logic [FL_PTR_W-1:0] cmt_rd_ptr;
    logic                do_pop;

    // same index with the wrap bit equal means nothing left to hand out
    assign empty  = (spec_rd_ptr == wr_ptr);
    assign do_pop = pop && !empty && !flush;

    assign free_phys = entries[spec_rd_ptr[FL_IDX_W-1:0]];

    // storage starts filled with every register above the arch range
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < FREE_DEPTH; i++)
            begin
                entries[i] <= phys_t'(NUM_ARCH + i);
            end
        end
        else if (push)
        begin
            entries[wr_ptr[FL_IDX_W-1:0]] <= push_phys;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            // full queue, write pointer one lap ahead
            wr_ptr      <= FL_PTR_W'(FREE_DEPTH);
            spec_rd_ptr <= '0;
            cmt_rd_ptr  <= '0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= wr_ptr + FL_PTR_W'(1);
            end

            if (commit_alloc)
            begin
                cmt_rd_ptr <= cmt_rd_ptr + FL_PTR_W'(1);
            end

            // rewind hands back everything allocated past the last commit
            if (flush)
            begin
                spec_rd_ptr <= cmt_rd_ptr;
            end
            else if (do_pop)
            begin
                spec_rd_ptr <= spec_rd_ptr + FL_PTR_W'(1);
            end
        end
    end

endmodule

//--- source/rrf.sv
module rrf (
    input  logic                clk,
    input  logic                rst,
    input  rename_pkg::commit_t commit,
    output rename_pkg::phys_t   committed_map [rename_pkg::NUM_ARCH],
    output logic                release_valid,
    output logic                commit_alloc,
    output rename_pkg::phys_t   release_phys
);
    import rename_pkg::*;

    // x0 commits never touch the map
    assign commit_alloc = commit.valid && commit.has_rd && (commit.arch != '0);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < NUM_ARCH; i++)
            begin
                committed_map[i] <= phys_t'(i);
            end
            release_valid <= 1'b0;
        end
        else
        begin
            release_valid <= commit_alloc;
            if (commit_alloc)
            begin
                committed_map[commit.arch] <= commit.phys;
            end
        end
    end

    // old committed entry goes back to the free list one edge later
    always_ff @(posedge clk)
    begin
        if (commit_alloc)
        begin
            release_phys <= committed_map[commit.arch];
        end
    end

endmodule

//--- source/rename_top.sv
module rename_top (
    input  logic                    clk,
    input  logic                    rst,
    input  rename_pkg::rename_req_t req,
    input  rename_pkg::wakeup_t     wake_alu,
    input  rename_pkg::wakeup_t     wake_mul,
    input  rename_pkg::wakeup_t     wake_ldst,
    input  rename_pkg::commit_t     commit,
    input  logic                    flush,
    output rename_pkg::renamed_t    out,
    output logic                    stall
);
    import rename_pkg::*;

    arch_t arch_rs1;
    arch_t arch_rs2;
    arch_t arch_rd;
    logic  writes_rd;
    logic  has_rd;
    logic  alloc;
    phys_t free_phys;
    logic  empty;
    phys_t prs1;
    phys_t prs2;
    phys_t old_prd;
    logic  rs1_ready;
    logic  rs2_ready;
    phys_t committed_map [NUM_ARCH];
    logic  release_valid;
    logic  commit_alloc;
    phys_t release_phys;

    rename_decode u_decode (
        .instr     (req.instr),
        .arch_rs1  (arch_rs1),
        .arch_rs2  (arch_rs2),
        .arch_rd   (arch_rd),
        .writes_rd (writes_rd)
    );

    assign has_rd = writes_rd && (arch_rd != '0);
    assign stall  = req.valid && writes_rd && empty;
    // flush beats a pending request
    assign alloc  = req.valid && has_rd && !empty && !flush;

    rat u_rat (
        .clk           (clk),
        .rst           (rst),
        .flush         (flush),
        .committed_map (committed_map),
        .arch_rs1      (arch_rs1),
        .arch_rs2      (arch_rs2),
        .arch_rd       (arch_rd),
        .alloc         (alloc),
        .alloc_phys    (free_phys),
        .wake_alu      (wake_alu),
        .wake_mul      (wake_mul),
        .wake_ldst     (wake_ldst),
        .prs1          (prs1),
        .prs2          (prs2),
        .old_prd       (old_prd),
        .rs1_ready     (rs1_ready),
        .rs2_ready     (rs2_ready)
    );

    free_list u_free_list (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .pop          (alloc),
        .commit_alloc (commit_alloc),
        .push         (release_valid),
        .push_phys    (release_phys),
        .free_phys    (free_phys),
        .empty        (empty)
    );

    rrf u_rrf (
        .clk           (clk),
        .rst           (rst),
        .commit        (commit),
        .committed_map (committed_map),
        .release_valid (release_valid),
        .commit_alloc  (commit_alloc),
        .release_phys  (release_phys)
    );

    // renamed view, sources come from the map before this rename lands
    always_comb
    begin
        out.valid     = req.valid && !stall && !flush;
        out.prs1      = prs1;
        out.prs2      = prs2;
        out.prd       = has_rd ? free_phys : '0;
        out.rs1_ready = rs1_ready;
        out.rs2_ready = rs2_ready;
        out.has_rd    = has_rd;
        out.old_prd   = old_prd;
    end

endmodule

//--- tb/rename_sva.sv
module rename_sva (
    input logic                    clk,
    input logic                    rst,
    input rename_pkg::rename_req_t req,
    input rename_pkg::wakeup_t     wake_alu,
    input rename_pkg::wakeup_t     wake_mul,
    input rename_pkg::wakeup_t     wake_ldst,
    input rename_pkg::commit_t     commit,
    input logic                    flush,
    input rename_pkg::renamed_t    out,
    input logic                    stall
);
    timeunit 1ns;
    timeprecision 100ps;
    import rename_pkg::*;

    int                  sva_errors = 0;
    wakeup_t             wk [NUM_WAKE];
    arch_t               rs1f;
    arch_t               rs2f;
    arch_t               rdf;
    logic                rd_op;
    logic                sb_op;
    logic                renamed;
    logic                cmt_now;
    logic                woke_prd;
    // shadow of the speculative and committed maps
    phys_t               pmap [NUM_ARCH];
    phys_t               cmap [NUM_ARCH];
    logic [NUM_ARCH-1:0] armed;
    // allocation history indexed by free list position order
    phys_t               hist [64];
    logic [5:0]          aidx;
    logic [5:0]          cnt_cmt;
    logic [6:0]          acnt;
    logic                any_cmt;
    arch_t               last_arch;
    phys_t               last_phys;
    logic                chk_look;
    logic                chk_prd;
    phys_t               exp_prd;
    logic                prev_ren;
    logic                prev_woke;
    arch_t               prev_rd;
    phys_t               prev_prd;

    assign wk[0]    = wake_alu;
    assign wk[1]    = wake_mul;
    assign wk[2]    = wake_ldst;
    assign rs1f     = req.instr.r_fmt.rs1;
    assign rs2f     = req.instr.r_fmt.rs2;
    assign rdf      = req.instr.r_fmt.rd;
    assign rd_op    = (req.instr.r_fmt.opcode == OP_REG) || (req.instr.r_fmt.opcode == OP_IMM);
    assign sb_op    = (req.instr.s_fmt.opcode == OP_STORE)
                   || (req.instr.s_fmt.opcode == OP_BRANCH);
    assign renamed  = out.valid && out.has_rd;
    assign cmt_now  = commit.valid && commit.has_rd && (commit.arch != '0);
    assign woke_prd = (wk[0].valid && wk[0].phys == out.prd)
                   || (wk[1].valid && wk[1].phys == out.prd)
                   || (wk[2].valid && wk[2].phys == out.prd);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < NUM_ARCH; i++)
            begin
                pmap[i] <= phys_t'(i);
                cmap[i] <= phys_t'(i);
            end
            armed    <= '0;
            aidx     <= '0;
            cnt_cmt  <= '0;
            acnt     <= '0;
            any_cmt  <= 1'b0;
            chk_look <= 1'b0;
            chk_prd  <= 1'b0;
            prev_ren <= 1'b0;
        end
        else
        begin
            prev_ren  <= renamed;
            prev_rd   <= rdf;
            prev_prd  <= out.prd;
            prev_woke <= woke_prd;
            chk_look  <= 1'b0;
            if (cmt_now)
            begin
                cmap[commit.arch] <= commit.phys;
                last_arch         <= commit.arch;
                last_phys         <= commit.phys;
                any_cmt           <= 1'b1;
                cnt_cmt           <= cnt_cmt + 6'd1;
            end
            if (flush)
            begin
                for (int i = 0; i < NUM_ARCH; i++)
                begin
                    pmap[i] <= cmap[i];
                end
                armed <= '0;
                aidx  <= cnt_cmt;
                if (!any_cmt)
                begin
                    acnt <= '0;
                end
                if (any_cmt && !cmt_now)
                begin
                    chk_look <= 1'b1;
                    chk_prd  <= (aidx > cnt_cmt);
                    exp_prd  <= hist[cnt_cmt];
                end
            end
            else
            begin
                for (int w = 0; w < NUM_WAKE; w++)
                begin
                    if (wk[w].valid && (wk[w].arch != '0) && (wk[w].phys == pmap[wk[w].arch]))
                    begin
                        armed[wk[w].arch] <= 1'b1;
                    end
                end
                // a new mapping for the arch drops any earlier wakeup
                if (renamed)
                begin
                    pmap[rdf]  <= out.prd;
                    armed[rdf] <= 1'b0;
                    hist[aidx] <= out.prd;
                    aidx       <= aidx + 6'd1;
                    acnt       <= acnt + 7'd1;
                    chk_prd    <= 1'b0;
                end
            end
        end
    end

    x0_rs1: assert property (@(posedge clk) disable iff (rst)
        (req.valid && rs1f == '0) |-> (out.prs1 == '0 && out.rs1_ready))
        else begin sva_errors++; $error("x0 rs1 lookup not phys 0 and ready"); end

    x0_rs2: assert property (@(posedge clk) disable iff (rst)
        (req.valid && rs2f == '0) |-> (out.prs2 == '0 && out.rs2_ready))
        else begin sva_errors++; $error("x0 rs2 lookup not phys 0 and ready"); end

    rd_flag: assert property (@(posedge clk) disable iff (rst)
        (req.valid && (rd_op || sb_op)) |-> (out.has_rd == (rd_op && rdf != '0)))
        else begin sva_errors++; $error("has_rd does not match the opcode"); end

    old_map: assert property (@(posedge clk) disable iff (rst)
        renamed |-> (out.old_prd == pmap[rdf]))
        else begin sva_errors++; $error("old_prd is not the displaced mapping"); end

    new_map_busy: assert property (@(posedge clk) disable iff (rst)
        (prev_ren && !prev_woke && req.valid && rd_op && rs1f == prev_rd)
        |-> (out.prs1 == prev_prd && !out.rs1_ready))
        else begin sva_errors++; $error("lookup after rename lost the new mapping"); end

    wake_ready: assert property (@(posedge clk) disable iff (rst)
        (req.valid && rd_op && rs1f != '0 && armed[rs1f]) |-> out.rs1_ready)
        else begin sva_errors++; $error("woken register still reads not ready"); end

    full_stall: assert property (@(posedge clk) disable iff (rst)
        (!any_cmt && acnt >= 7'd32 && req.valid && rd_op) |-> (stall && !out.valid))
        else begin sva_errors++; $error("empty free list did not stall"); end

    store_no_stall: assert property (@(posedge clk) disable iff (rst)
        (req.valid && req.instr.s_fmt.opcode == OP_STORE) |-> !stall)
        else begin sva_errors++; $error("store stalled"); end

    flush_map: assert property (@(posedge clk) disable iff (rst)
        (chk_look && req.valid && rd_op && rs1f == last_arch)
        |-> (out.prs1 == last_phys && out.rs1_ready))
        else begin sva_errors++; $error("flush did not restore the committed map"); end

    flush_prd: assert property (@(posedge clk) disable iff (rst)
        (chk_prd && renamed) |-> (out.prd == exp_prd))
        else begin sva_errors++; $error("flush did not rewind the free list"); end

endmodule

bind rename_top rename_sva u_sva (.*);

//--- tb/rename_tb.sv
module rename_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import rename_pkg::*;

    localparam int FILL_COUNT   = 32;
    localparam int RAND_COUNT   = 24;
    localparam int COMMIT_COUNT = 16;
    localparam int TEST_CYCLES  = 8 + FILL_COUNT + 4 + 2 * RAND_COUNT + 3 * COMMIT_COUNT + 16;

    logic        clk;
    logic        rst;
    rename_req_t req;
    wakeup_t     wake_alu;
    wakeup_t     wake_mul;
    wakeup_t     wake_ldst;
    commit_t     commit;
    logic        flush;
    renamed_t    out;
    logic        stall;

    logic [15:0] lfsr;
    int          errors;
    int          total;
    wakeup_t     pend_wake [NUM_WAKE];
    renamed_t    seen;
    arch_t       ren_arch [$];
    phys_t       ren_phys [$];
    arch_t       prev_rd;
    arch_t       rd;
    arch_t       rs1;
    arch_t       rs2;
    logic [4:0]  pick;
    int          idx;

    rename_top u_rename_top (.*);

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic rand_bits(input int n, output logic [4:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_next(lfsr);
            v    = {v[3:0], lfsr[0]};
        end
    endtask

    function automatic logic [31:0] r_word(arch_t d, arch_t s1, arch_t s2);
        return {7'b0, s2, s1, 3'b000, d, OP_REG};
    endfunction

    function automatic logic [31:0] i_word(arch_t d, arch_t s1);
        return {12'h011, s1, 3'b000, d, OP_IMM};
    endfunction

    function automatic logic [31:0] s_word(arch_t s1, arch_t s2);
        return {7'h0, s2, s1, 3'b010, 5'h08, OP_STORE};
    endfunction

    function automatic logic [31:0] b_word(arch_t s1, arch_t s2);
        return {7'h0, s2, s1, 3'b000, 5'h0a, OP_BRANCH};
    endfunction

    // one request cycle, outputs sampled mid-cycle
    task automatic send(input logic [31:0] word);
        @(posedge clk);
        req.valid <= 1'b1;
        req.instr <= word;
        wake_alu  <= pend_wake[0];
        wake_mul  <= pend_wake[1];
        wake_ldst <= pend_wake[2];
        commit    <= '0;
        flush     <= 1'b0;
        pend_wake[0] = '0;
        pend_wake[1] = '0;
        pend_wake[2] = '0;
        @(negedge clk);
        seen = out;
        if (seen.valid && seen.has_rd)
        begin
            ren_arch.push_back(word[11:7]);
            ren_phys.push_back(seen.prd);
        end
    endtask

    task automatic quiet(input logic do_flush, input commit_t c);
        @(posedge clk);
        req.valid <= 1'b0;
        wake_alu  <= '0;
        wake_mul  <= '0;
        wake_ldst <= '0;
        commit    <= c;
        flush     <= do_flush;
    endtask

    initial
    begin
        #((TEST_CYCLES + 200) * 4);
        $display("watchdog timeout, the test did not finish in time");
        $display("CHECKS FAILED");
        $finish;
    end

    initial
    begin
        lfsr      = 16'd20758;
        errors    = 0;
        rst       = 1'b1;
        req       = '0;
        wake_alu  = '0;
        wake_mul  = '0;
        wake_ldst = '0;
        commit    = '0;
        flush     = 1'b0;
        pend_wake[0] = '0;
        pend_wake[1] = '0;
        pend_wake[2] = '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        // drain the free list, each source reads the previous destination
        prev_rd = 5'd1;
        for (int i = 0; i < FILL_COUNT; i++)
        begin
            rd = arch_t'(i % 31 + 1);
            send(r_word(rd, prev_rd, arch_t'(i % 7)));
            if (seen.prd != phys_t'(NUM_ARCH + i))
            begin
                errors++;
                $display("[FAIL] %0t free_phys %0d, expected %0d", $time, seen.prd, NUM_ARCH + i);
            end
            prev_rd = rd;
        end
        send(i_word(5'd5, 5'd3));
        send(s_word(5'd1, 5'd2));
        quiet(1'b1, '0);
        ren_arch.delete();
        ren_phys.delete();

        // random traffic, wakeups aimed at recent renames
        for (int i = 0; i < RAND_COUNT; i++)
        begin
            rand_bits(5, rd);
            rand_bits(5, rs1);
            rand_bits(5, rs2);
            rand_bits(1, pick);
            if (pick[0] && i > 0)
            begin
                rs1 = prev_rd;
            end
            if (rd == '0)
            begin
                rd = 5'd1;
            end
            if (ren_arch.size() > 0)
            begin
                rand_bits(3, pick);
                idx = ren_arch.size() - 1 - (int'(pick) % ren_arch.size());
                pend_wake[i % NUM_WAKE] = '{valid: 1'b1, arch: ren_arch[idx], phys: ren_phys[idx]};
            end
            send((i % 2 == 1) ? i_word(rd, rs1) : r_word(rd, rs1, rs2));
            if (i % 5 == 4)
            begin
                send(b_word(rs1, rs2));
            end
            prev_rd = rd;
        end

        // commit the oldest renames in order
        for (int i = 0; i < COMMIT_COUNT; i++)
        begin
            quiet(1'b0, '{valid: 1'b1, has_rd: 1'b1, arch: ren_arch[i], phys: ren_phys[i]});
        end
        quiet(1'b0, '0);
        quiet(1'b0, '0);

        quiet(1'b1, '0);
        send(i_word(5'd7, ren_arch[COMMIT_COUNT-1]));
        send(r_word(5'd9, 5'd7, ren_arch[0]));
        // wake the new x9 and read it back one cycle later
        pend_wake[0] = '{valid: 1'b1, arch: 5'd9, phys: seen.prd};
        send(i_word(5'd10, 5'd0));
        send(i_word(5'd11, 5'd9));
        quiet(1'b0, '0);
        repeat (4) @(posedge clk);

        total = errors + u_rename_top.u_sva.sva_errors;
        $display("errors: %0d testbench, %0d assertion", errors, u_rename_top.u_sva.sva_errors);
        if (total == 0)
        begin
            $display("ALL CHECKS PASSED");
        end
        else
        begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- vlog.f
source/rename_pkg.sv
source/rename_decode.sv
source/rat.sv
source/free_list.sv
source/rrf.sv
source/rename_top.sv
tb/rename_sva.sv
tb/rename_tb.sv

//--- Makefile
SHELL     := /bin/bash
VERILATOR ?= verilator
TOP       ?= rename_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= CHECKS FAILED
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: simulate clean

simulate:
	$(VERILATOR) --binary --assert --timing -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	set -o pipefail; ./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
